// ==== sb_cfg.svh ====
// ==========================================================
// All addresses are word addresses
// A window holds its low bound and excludes its high bound
// FIFO depth must be a power of two
// ==========================================================

`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// Scratch RAM window and size
`define SB_RAM_LOW    32'h0000_1000
`define SB_RAM_HIGH   32'h0000_1040
`define SB_RAM_WORDS  64

// FIFO window and depth
`define SB_FIFO_LOW   32'h0000_2000
`define SB_FIFO_HIGH  32'h0000_2004
`define SB_FIFO_DEPTH 16

// Word indices inside the FIFO window
// Push and pop share index 0 and differ by strobe
`define SB_FIFO_PUSH  8'h00
`define SB_FIFO_POP   8'h00
`define SB_FIFO_STAT  8'h01

`endif

// ==== sb_pkg.sv ====
// ==========================================================
// Bus word and address types shared by the subsystem
// Slaves decode only the low 8-bit word index
// ==========================================================

`default_nettype none

package sb_pkg;

        localparam int SB_DATA_WIDTH = 32;

        typedef logic [SB_DATA_WIDTH-1:0] sb_word_t;

        // Region tag above the word index
        typedef struct packed {
                logic [23:0] region;
                logic [7:0]  index;
        } sb_addr_fields_t;

        // One address word seen whole or split into fields
        typedef union packed {
                logic [31:0]     raw;
                sb_addr_fields_t field;
        } sb_addr_u;

endpackage

`default_nettype wire

// ==== sb_interconnect.sv ====
// ==========================================================
// One master, two slaves, one register stage each way
// Unmapped writes are dropped and unmapped reads return zero
// ==========================================================

`timescale 1ns/1ps
`default_nettype none
`include "sb_cfg.svh"

module sb_interconnect
        import sb_pkg::*;
(
        input  wire      clock,
        input  wire      reset,
        input  wire      sb_addr_u sb_address,
        input  wire      sb_write_strobe,
        input  wire      sb_read_strobe,
        input  wire      sb_word_t sb_write_data,
        output sb_word_t sb_read_data,
        output logic     sb_ready,
        output sb_addr_u ram_address,
        output logic     ram_write_strobe,
        output logic     ram_read_strobe,
        output sb_word_t ram_write_data,
        input  wire      sb_word_t ram_read_data,
        input  wire      ram_ready,
        output sb_addr_u fifo_address,
        output logic     fifo_write_strobe,
        output logic     fifo_read_strobe,
        output sb_word_t fifo_write_data,
        input  wire      sb_word_t fifo_read_data,
        input  wire      fifo_ready
);

        logic ram_hit;
        logic fifo_hit;

        // Window match on the whole address
        assign ram_hit  = (sb_address.raw >= `SB_RAM_LOW) && (sb_address.raw < `SB_RAM_HIGH);
        assign fifo_hit = (sb_address.raw >= `SB_FIFO_LOW) && (sb_address.raw < `SB_FIFO_HIGH);

        // Only the selected slave sees a strobe
        always_ff @(posedge clock) begin
                if (reset) begin
                        ram_write_strobe  <= 1'b0;
                        ram_read_strobe   <= 1'b0;
                        fifo_write_strobe <= 1'b0;
                        fifo_read_strobe  <= 1'b0;
                end else begin
                        ram_write_strobe  <= ram_hit & sb_write_strobe;
                        ram_read_strobe   <= ram_hit & sb_read_strobe;
                        fifo_write_strobe <= fifo_hit & sb_write_strobe;
                        fifo_read_strobe  <= fifo_hit & sb_read_strobe;
                end
        end

        // Address and write data
        always_ff @(posedge clock) begin
                ram_address     <= ram_hit ? sb_address : '0;
                ram_write_data  <= ram_hit ? sb_write_data : '0;
                fifo_address    <= fifo_hit ? sb_address : '0;
                fifo_write_data <= fifo_hit ? sb_write_data : '0;
        end

        // Idle slaves return zero so the responses merge by OR
        always_ff @(posedge clock) begin
                if (reset) begin
                        sb_read_data <= '0;
                        sb_ready     <= 1'b0;
                end else begin
                        sb_read_data <= ram_read_data | fifo_read_data;
                        sb_ready     <= ram_ready & fifo_ready;
                end
        end

endmodule

`default_nettype wire

// ==== sb_scratch_ram.sv ====
// ==========================================================
// Contents are undefined until written
// Read data is zero in cycles without a read
// ==========================================================

`timescale 1ns/1ps
`default_nettype none
`include "sb_cfg.svh"

module sb_scratch_ram
        import sb_pkg::*;
(
        input  wire      clock,
        input  wire      reset,
        input  wire      sb_addr_u address,
        input  wire      write_strobe,
        input  wire      read_strobe,
        input  wire      sb_word_t write_data,
        output sb_word_t read_data,
        output logic     ready
);

        localparam int INDEX_WIDTH = $clog2(`SB_RAM_WORDS);

        sb_word_t               mem [0:`SB_RAM_WORDS-1];
        logic [INDEX_WIDTH-1:0] index;

        // Upper index bits are zero inside the window
        assign index = address.field.index[INDEX_WIDTH-1:0];

        always_ff @(posedge clock) begin
                if (write_strobe) begin
                        mem[index] <= write_data;
                end
        end

        always_ff @(posedge clock) begin
                if (reset) begin
                        read_data <= '0;
                        ready     <= 1'b0;
                end else begin
                        read_data <= read_strobe ? mem[index] : '0;
                        ready     <= 1'b1;
                end
        end

endmodule

`default_nettype wire

// ==== sb_fifo_slave.sv ====
// ==========================================================
// Push into a full FIFO is dropped and sets a sticky overflow
// Pop from an empty FIFO returns zero and changes nothing
// ==========================================================

`timescale 1ns/1ps
`default_nettype none
`include "sb_cfg.svh"

module sb_fifo_slave
        import sb_pkg::*;
(
        input  wire      clock,
        input  wire      reset,
        input  wire      sb_addr_u address,
        input  wire      write_strobe,
        input  wire      read_strobe,
        input  wire      sb_word_t write_data,
        output sb_word_t read_data,
        output logic     ready
);

        localparam int PTR_WIDTH   = $clog2(`SB_FIFO_DEPTH);
        localparam int COUNT_WIDTH = PTR_WIDTH + 1;

        sb_word_t               buffer [0:`SB_FIFO_DEPTH-1];
        logic [PTR_WIDTH-1:0]   wr_ptr;
        logic [PTR_WIDTH-1:0]   rd_ptr;
        logic [COUNT_WIDTH-1:0] count;
        logic                   overflow;
        logic                   full;
        logic                   empty;
        logic                   push_req;
        logic                   pop_req;
        logic                   stat_req;
        logic                   push_ok;
        logic                   pop_ok;
        sb_word_t               status_word;

        assign push_req = write_strobe && (address.field.index == `SB_FIFO_PUSH);
        assign pop_req  = read_strobe && (address.field.index == `SB_FIFO_POP);
        assign stat_req = read_strobe && (address.field.index == `SB_FIFO_STAT);

        assign full    = (count == COUNT_WIDTH'(`SB_FIFO_DEPTH));
        assign empty   = (count == '0);
        assign push_ok = push_req && !full;
        assign pop_ok  = pop_req && !empty;

        // Overflow in bit 31, fill count in the low bits
        always_comb begin
                status_word = '0;
                status_word[SB_DATA_WIDTH-1] = overflow;
                status_word[COUNT_WIDTH-1:0] = count;
        end

        always_ff @(posedge clock) begin
                if (push_ok) begin
                        buffer[wr_ptr] <= write_data;
                end
        end

        always_ff @(posedge clock) begin
                if (reset) begin
                        wr_ptr    <= '0;
                        rd_ptr    <= '0;
                        count     <= '0;
                        overflow  <= 1'b0;
                        read_data <= '0;
                        ready     <= 1'b0;
                end else begin
                        ready <= 1'b1;
                        if (push_ok) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (pop_ok) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        if (push_ok && !pop_ok) begin
                                count <= count + 1'b1;
                        end else if (pop_ok && !push_ok) begin
                                count <= count - 1'b1;
                        end
                        // Sticky until reset
                        if (push_req && full) begin
                                overflow <= 1'b1;
                        end
                        if (pop_ok) begin
                                read_data <= buffer[rd_ptr];
                        end else if (stat_req) begin
                                read_data <= status_word;
                        end else begin
                                read_data <= '0;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== sb_subsystem.sv ====
// ==========================================================
// Read data is valid three edges after the read strobe
// sb_ready rises two cycles after reset and stays high
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module sb_subsystem
        import sb_pkg::*;
(
        input  wire      clock,
        input  wire      reset,
        input  wire      sb_addr_u sb_address,
        input  wire      sb_write_strobe,
        input  wire      sb_read_strobe,
        input  wire      sb_word_t sb_write_data,
        output sb_word_t sb_read_data,
        output logic     sb_ready
);

        // Scratch RAM port
        sb_addr_u ram_address;
        logic     ram_write_strobe;
        logic     ram_read_strobe;
        sb_word_t ram_write_data;
        sb_word_t ram_read_data;
        logic     ram_ready;

        // FIFO port
        sb_addr_u fifo_address;
        logic     fifo_write_strobe;
        logic     fifo_read_strobe;
        sb_word_t fifo_write_data;
        sb_word_t fifo_read_data;
        logic     fifo_ready;

        sb_interconnect interconnect0 (
                .clock             (clock),
                .reset             (reset),
                .sb_address        (sb_address),
                .sb_write_strobe   (sb_write_strobe),
                .sb_read_strobe    (sb_read_strobe),
                .sb_write_data     (sb_write_data),
                .sb_read_data      (sb_read_data),
                .sb_ready          (sb_ready),
                .ram_address       (ram_address),
                .ram_write_strobe  (ram_write_strobe),
                .ram_read_strobe   (ram_read_strobe),
                .ram_write_data    (ram_write_data),
                .ram_read_data     (ram_read_data),
                .ram_ready         (ram_ready),
                .fifo_address      (fifo_address),
                .fifo_write_strobe (fifo_write_strobe),
                .fifo_read_strobe  (fifo_read_strobe),
                .fifo_write_data   (fifo_write_data),
                .fifo_read_data    (fifo_read_data),
                .fifo_ready        (fifo_ready)
        );

        sb_scratch_ram ram0 (
                .clock        (clock),
                .reset        (reset),
                .address      (ram_address),
                .write_strobe (ram_write_strobe),
                .read_strobe  (ram_read_strobe),
                .write_data   (ram_write_data),
                .read_data    (ram_read_data),
                .ready        (ram_ready)
        );

        sb_fifo_slave fifo0 (
                .clock        (clock),
                .reset        (reset),
                .address      (fifo_address),
                .write_strobe (fifo_write_strobe),
                .read_strobe  (fifo_read_strobe),
                .write_data   (fifo_write_data),
                .read_data    (fifo_read_data),
                .ready        (fifo_ready)
        );

endmodule

`default_nettype wire

// ==== sb_asserts.sv ====
// ==========================================================
// Bound to sb_interconnect, checks the slave-side signals
// Disabled while reset is high
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module sb_asserts (
        input wire        clock,
        input wire        reset,
        input wire        ram_write_strobe,
        input wire        ram_read_strobe,
        input wire        fifo_write_strobe,
        input wire        fifo_read_strobe,
        input wire [31:0] ram_read_data,
        input wire [31:0] fifo_read_data
);

        // At most one slave addressed per cycle
        one_slave_strobed: assert property (@(posedge clock) disable iff (reset)
                !((ram_write_strobe || ram_read_strobe) &&
                  (fifo_write_strobe || fifo_read_strobe)))
                else $error("both slaves strobed in one cycle");

        ram_one_command: assert property (@(posedge clock) disable iff (reset)
                !(ram_write_strobe && ram_read_strobe))
                else $error("RAM read and write strobes together");

        fifo_one_command: assert property (@(posedge clock) disable iff (reset)
                !(fifo_write_strobe && fifo_read_strobe))
                else $error("FIFO read and write strobes together");

        // Idle slaves must return zero for the OR merge
        ram_idle_zero: assert property (@(posedge clock) disable iff (reset)
                !$past(ram_read_strobe) |-> (ram_read_data == '0))
                else $error("RAM drives read data without a read");

        fifo_idle_zero: assert property (@(posedge clock) disable iff (reset)
                !$past(fifo_read_strobe) |-> (fifo_read_data == '0))
                else $error("FIFO drives read data without a read");

endmodule

bind sb_interconnect sb_asserts asserts0 (
        .clock             (clock),
        .reset             (reset),
        .ram_write_strobe  (ram_write_strobe),
        .ram_read_strobe   (ram_read_strobe),
        .fifo_write_strobe (fifo_write_strobe),
        .fifo_read_strobe  (fifo_read_strobe),
        .ram_read_data     (ram_read_data),
        .fifo_read_data    (fifo_read_data)
);

`default_nettype wire

// ==== tb_sb_subsystem.sv ====
// ==========================================================
// Runs the bus operations of sb_golden.txt, one per cycle
// Reads are checked three cycles after they are driven
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module tb_sb_subsystem
        import sb_pkg::*;
;

        localparam int READ_LATENCY  = 3;
        localparam int READY_TIMEOUT = 50;
        localparam int DRAIN_TIMEOUT = 10;

        logic     clock;
        logic     reset;
        sb_addr_u sb_address;
        logic     sb_write_strobe;
        logic     sb_read_strobe;
        sb_word_t sb_write_data;
        sb_word_t sb_read_data;
        logic     sb_ready;

        // Reads in flight, oldest first
        logic [31:0] expect_q [$];
        logic [31:0] addr_q [$];
        int          due_q [$];
        int          slot;

        sb_subsystem dut0 (
                .clock           (clock),
                .reset           (reset),
                .sb_address      (sb_address),
                .sb_write_strobe (sb_write_strobe),
                .sb_read_strobe  (sb_read_strobe),
                .sb_write_data   (sb_write_data),
                .sb_read_data    (sb_read_data),
                .sb_ready        (sb_ready)
        );

        initial begin
                clock = 1'b0;
                forever begin
                        #2 clock = ~clock;
                end
        end

        task automatic stop_on_error(input string msg);
                $display("%s", msg);
                $display("ERRORS FOUND");
                $fatal(1, "simulation stopped");
        endtask

        // Moves to the next drive point, 1 ns after the rising edge
        task automatic next_slot();
                @(posedge clock);
                #1;
                slot++;
        endtask

        task automatic check_due_reads();
                while (due_q.size() > 0 && due_q[0] == slot) begin
                        assert (sb_read_data === expect_q[0]) else
                                stop_on_error($sformatf(
                                        "FAIL %0t: read from %h returned %h, expected %h",
                                        $time, addr_q[0], sb_read_data, expect_q[0]));
                        void'(expect_q.pop_front());
                        void'(addr_q.pop_front());
                        void'(due_q.pop_front());
                end
        endtask

        task automatic drive_idle();
                sb_address      = '0;
                sb_write_strobe = 1'b0;
                sb_read_strobe  = 1'b0;
                sb_write_data   = '0;
        endtask

        initial begin
                int          fd;
                int          waited;
                int          fields;
                string       line;
                byte         op;
                logic [31:0] addr;
                logic [31:0] wdata;
                logic [31:0] expected;

                slot  = 0;
                reset = 1'b1;
                drive_idle();
                repeat (10) @(posedge clock);
                #1;
                reset = 1'b0;

                waited = 0;
                while (!sb_ready) begin
                        if (waited == READY_TIMEOUT) begin
                                stop_on_error("Timeout: sb_ready never rose after reset");
                        end
                        next_slot();
                        waited++;
                end

                fd = $fopen("sb_golden.txt", "r");
                if (fd == 0) begin
                        stop_on_error("Could not open sb_golden.txt");
                end

                while (!$feof(fd)) begin
                        line = "";
                        void'($fgets(line, fd));
                        if (line.len() < 2 || line[0] == "#") begin
                                continue;
                        end
                        fields = $sscanf(line, "%c %h %h %h", op, addr, wdata, expected);
                        if (fields != 4) begin
                                stop_on_error($sformatf("Malformed golden line: %s", line));
                        end
                        next_slot();
                        check_due_reads();
                        assert (sb_ready === 1'b1) else
                                stop_on_error($sformatf("FAIL %0t: sb_ready dropped", $time));
                        drive_idle();
                        case (op)
                                "W": begin
                                        sb_address      = addr;
                                        sb_write_data   = wdata;
                                        sb_write_strobe = 1'b1;
                                end
                                "R": begin
                                        sb_address     = addr;
                                        sb_read_strobe = 1'b1;
                                        expect_q.push_back(expected);
                                        addr_q.push_back(addr);
                                        // Valid at the third drive point from here
                                        due_q.push_back(slot + READ_LATENCY);
                                end
                                "I": begin
                                end
                                default: begin
                                        stop_on_error($sformatf("Unknown operation %c", op));
                                end
                        endcase
                end
                $fclose(fd);

                waited = 0;
                while (due_q.size() > 0) begin
                        if (waited == DRAIN_TIMEOUT) begin
                                stop_on_error("Timeout: outstanding reads never completed");
                        end
                        next_slot();
                        drive_idle();
                        check_due_reads();
                        waited++;
                end

                $display("NO ERRORS");
                $finish;
        end

endmodule

`default_nettype wire

// ==== sb_golden.txt ====
# op (W write, R read, I idle), address, write data, expected read data, all hex
# expected is checked only on R lines
I 00000000 00000000 00000000
W 00001000 11111111 00000000
W 00001005 a5a5a5a5 00000000
W 0000103f deadbeef 00000000
W 00001020 12345678 00000000
R 00001000 00000000 11111111
R 00001005 00000000 a5a5a5a5
R 0000103f 00000000 deadbeef
R 00001020 00000000 12345678
R 00002001 00000000 00000000
W 00002000 aaaa0001 00000000
W 00002000 aaaa0002 00000000
W 00002000 aaaa0003 00000000
R 00002001 00000000 00000003
R 00002000 00000000 aaaa0001
R 00002000 00000000 aaaa0002
R 00002001 00000000 00000001
R 00002000 00000000 aaaa0003
R 00002000 00000000 00000000
R 00002001 00000000 00000000
W 00001040 bad00001 00000000
W 00002004 bad00002 00000000
W 00000000 bad00003 00000000
W 00002001 bad00004 00000000
R 00001040 00000000 00000000
R 00002004 00000000 00000000
R 00003000 00000000 00000000
R 00000fff 00000000 00000000
R 00001000 00000000 11111111
R 0000103f 00000000 deadbeef
R 00002001 00000000 00000000
W 00002000 00000001 00000000
W 00002000 00000002 00000000
W 00002000 00000003 00000000
W 00002000 00000004 00000000
W 00002000 00000005 00000000
W 00002000 00000006 00000000
W 00002000 00000007 00000000
W 00002000 00000008 00000000
W 00002000 00000009 00000000
W 00002000 0000000a 00000000
W 00002000 0000000b 00000000
W 00002000 0000000c 00000000
W 00002000 0000000d 00000000
W 00002000 0000000e 00000000
W 00002000 0000000f 00000000
W 00002000 00000010 00000000
W 00002000 00000011 00000000
R 00002001 00000000 80000010
R 00002000 00000000 00000001
R 00002000 00000000 00000002
R 00002000 00000000 00000003
R 00002000 00000000 00000004
R 00002000 00000000 00000005
R 00002000 00000000 00000006
R 00002000 00000000 00000007
R 00002000 00000000 00000008
R 00002000 00000000 00000009
R 00002000 00000000 0000000a
R 00002000 00000000 0000000b
R 00002000 00000000 0000000c
R 00002000 00000000 0000000d
R 00002000 00000000 0000000e
R 00002000 00000000 0000000f
R 00002000 00000000 00000010
R 00002001 00000000 80000000
R 00002000 00000000 00000000
I 00000000 00000000 00000000

// ==== vlog.f ====
+incdir+.
sb_pkg.sv
sb_interconnect.sv
sb_scratch_ram.sv
sb_fifo_slave.sv
sb_subsystem.sv
sb_asserts.sv
tb_sb_subsystem.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_sb_subsystem -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean
